//--- project.f
hw/rvv_pkg.sv
hw/multi_fifo.sv
hw/rvv_decode.sv
hw/rvv_dispatch.sv
hw/rvv_alu.sv
hw/rvv_vrf.sv
hw/rvv_backend.sv
tests/tb_rvv_backend.sv

//--- Bender.yml
package:
  name: rvv_backend

sources:
  - hw/rvv_pkg.sv
  - hw/multi_fifo.sv
  - hw/rvv_decode.sv
  - hw/rvv_dispatch.sv
  - hw/rvv_alu.sv
  - hw/rvv_vrf.sv
  - hw/rvv_backend.sv
  - target: test
    files:
      - tests/tb_rvv_backend.sv

//--- tests/tb_rvv_backend.sv
`timescale 1ns/1ps

module tb_rvv_backend;

    localparam int VLEN       = rvv_pkg::VLEN;
    localparam int CQ_DEPTH   = 8;
    localparam int UQ_DEPTH   = 4;
    localparam int N_DIRECTED = 10;
    localparam int N_RANDOM   = 80;
    localparam int N_BURST    = 60;
    localparam int TIMEOUT_CYCLES = 20 * (N_DIRECTED + N_RANDOM + N_BURST) + 200;

    // Command kinds used by the generator
    localparam int K_ADD     = 0;
    localparam int K_SUB     = 1;
    localparam int K_BAD_OPC = 2;
    localparam int K_BAD_F3  = 3;
    localparam int K_BAD_F6  = 4;
    localparam int K_BAD_SEW = 5;

    typedef struct packed {
        logic [31:0]     pc;
        logic [4:0]      vd;
        logic [VLEN-1:0] data;
        logic            illegal;
    } exp_t;

    logic                                        clk;
    logic                                        rst_n;
    logic [rvv_pkg::ISSUE_LANE-1:0]              insts_valid;
    rvv_pkg::rvv_cmd_t [rvv_pkg::ISSUE_LANE-1:0] insts;
    logic [rvv_pkg::ISSUE_LANE-1:0]              insts_ready;
    logic                                        rt_valid;
    logic [31:0]                                 rt_pc;
    logic [rvv_pkg::VREG_IDX_W-1:0]              rt_vd;
    logic [VLEN-1:0]                             rt_data;
    logic                                        rt_illegal;

    rvv_pkg::rvv_cmd_t pend_q[$];
    exp_t              exp_q[$];
    logic [VLEN-1:0]   vrf_m [rvv_pkg::NUM_VREG];
    integer            seed;
    logic [31:0]       next_pc;
    int                cycles = 0;
    int                err_value = 0;
    int                err_other = 0;
    logic              rst_prev = 1'b0;
    logic              in_burst;
    logic              saw_ready_low = 1'b0;

    rvv_backend #(
        .CQ_DEPTH (CQ_DEPTH),
        .UQ_DEPTH (UQ_DEPTH)
    ) dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .insts_valid (insts_valid),
        .insts       (insts),
        .insts_ready (insts_ready),
        .rt_valid    (rt_valid),
        .rt_pc       (rt_pc),
        .rt_vd       (rt_vd),
        .rt_data     (rt_data),
        .rt_illegal  (rt_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    ready_prefix: assert property (@(posedge clk)
        (cycles > 0) |-> (!insts_ready[1] || insts_ready[0]))
        else begin
            err_other++;
            $display("insts_ready[1] was high while insts_ready[0] was low at %0t", $time);
        end

    reset_quiet: assert property (@(posedge clk)
        (cycles > 0 && (!rst_n || !rst_prev)) |-> !rt_valid)
        else begin
            err_other++;
            $display("rt_valid was high during reset or the cycle after at %0t", $time);
        end

    // Element-wise vs2 op vs1, each element wrapped at its width
    function automatic logic [VLEN-1:0] model_alu(input logic [VLEN-1:0] a,
                                                  input logic [VLEN-1:0] b,
                                                  input bit sub, input int ew);
        logic [VLEN-1:0] r;
        logic [31:0]     mask;
        logic [31:0]     ea;
        logic [31:0]     eb;
        logic [31:0]     er;
        r = '0;
        mask = (ew == 32) ? 32'hffff_ffff : ((32'd1 << ew) - 32'd1);
        for (int e = 0; e < VLEN / ew; e++) begin
            ea = 32'(a >> (e * ew)) & mask;
            eb = 32'(b >> (e * ew)) & mask;
            er = (sub ? ea - eb : ea + eb) & mask;
            r = r | (VLEN'(er) << (e * ew));
        end
        return r;
    endfunction

    task automatic compare_field(input string name, input logic [VLEN-1:0] expected,
                                 input logic [VLEN-1:0] actual);
        assert (expected === actual)
            else begin
                err_value++;
                $display("mismatch at %0t: %s expected %0h got %0h",
                         $time, name, expected, actual);
            end
    endtask

    // Executes one accepted command on the model register file
    task automatic model_accept(input rvv_pkg::rvv_cmd_t c);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [5:0] f6;
        logic [4:0] vd;
        logic [4:0] vs1;
        logic [4:0] vs2;
        int         ew;
        exp_t       e;
        opc = c.inst[6:0];
        f3  = c.inst[14:12];
        f6  = c.inst[31:26];
        vd  = c.inst[11:7];
        vs1 = c.inst[19:15];
        vs2 = c.inst[24:20];
        ew  = (c.sew == 2'd0) ? 8 : (c.sew == 2'd1) ? 16 : 32;
        e.pc = c.pc;
        e.vd = vd;
        e.illegal = (opc != rvv_pkg::OPC_OP_V) || (f3 != rvv_pkg::F3_OPIVV) ||
                    (f6 != rvv_pkg::F6_VADD && f6 != rvv_pkg::F6_VSUB) || (c.sew == 2'd3);
        if (e.illegal) begin
            e.data = '0;
        end else begin
            e.data = model_alu(vrf_m[vs2], vrf_m[vs1], f6 == rvv_pkg::F6_VSUB, ew);
            vrf_m[vd] = e.data;
        end
        exp_q.push_back(e);
    endtask

    // Retire checks first, then new acceptances, all on pre-edge values
    always @(posedge clk) begin
        exp_t e;
        rst_prev <= rst_n;
        if (rst_n) begin
            if (rt_valid) begin
                if (exp_q.size() == 0) begin
                    err_other++;
                    $display("retire of pc %0h at %0t with no accepted command left",
                             rt_pc, $time);
                end else begin
                    e = exp_q.pop_front();
                    compare_field("rt_pc", e.pc, rt_pc);
                    compare_field("rt_vd", e.vd, rt_vd);
                    compare_field("rt_illegal", e.illegal, rt_illegal);
                    compare_field("rt_data", e.data, rt_data);
                end
            end
            for (int k = 0; k < rvv_pkg::ISSUE_LANE; k++) begin
                if (insts_valid[k] && insts_ready[k]) begin
                    model_accept(insts[k]);
                end
            end
            if (in_burst && !insts_ready[1]) begin
                saw_ready_low <= 1'b1;
            end
        end
    end

    task automatic add_cmd(input int kind, input int vd, input int vs1, input int vs2,
                           input int sew);
        rvv_pkg::rvv_cmd_t c;
        logic [6:0] opc;
        logic [2:0] f3;
        logic [5:0] f6;
        logic [1:0] s;
        opc = rvv_pkg::OPC_OP_V;
        f3  = rvv_pkg::F3_OPIVV;
        f6  = (kind == K_SUB) ? rvv_pkg::F6_VSUB : rvv_pkg::F6_VADD;
        s   = 2'(sew);
        case (kind)
            K_BAD_OPC: opc = 7'b0110011;
            K_BAD_F3:  f3 = 3'b011;
            K_BAD_F6:  f6 = 6'b100101;
            K_BAD_SEW: s = 2'd3;
            default: ;
        endcase
        c.pc   = next_pc;
        c.inst = {f6, 1'b1, 5'(vs2), 5'(vs1), f3, 5'(vd), opc};
        c.sew  = rvv_pkg::sew_e'(s);
        next_pc = next_pc + 32'd4;
        pend_q.push_back(c);
    endtask

    // Mostly legal, registers 0..3 so dependences are frequent
    task automatic add_random_cmd();
        int pick;
        int kind;
        pick = $unsigned($random(seed)) % 8;
        if (pick < 3) begin
            kind = K_ADD;
        end else if (pick < 6) begin
            kind = K_SUB;
        end else begin
            kind = K_BAD_OPC + $unsigned($random(seed)) % 4;
        end
        add_cmd(kind, $unsigned($random(seed)) % 4, $unsigned($random(seed)) % 4,
                $unsigned($random(seed)) % 4, $unsigned($random(seed)) % 3);
    endtask

    // Presents the head of pend_q on a prefix of lanes until all are taken
    task automatic run_stream(input bit burst);
        int n_acc;
        int n_lanes;
        while (pend_q.size() != 0) begin
            @(posedge clk);
            n_acc = 0;
            if (insts_valid[0] && insts_ready[0]) begin
                n_acc = (insts_valid[1] && insts_ready[1]) ? 2 : 1;
            end
            repeat (n_acc) void'(pend_q.pop_front());
            n_lanes = burst ? 2 : $unsigned($random(seed)) % 3;
            if (n_lanes > pend_q.size()) begin
                n_lanes = pend_q.size();
            end
            insts_valid <= (n_lanes == 2) ? 2'b11 : (n_lanes == 1) ? 2'b01 : 2'b00;
            if (n_lanes > 0) begin
                insts[0] <= pend_q[0];
            end
            if (n_lanes > 1) begin
                insts[1] <= pend_q[1];
            end
        end
    endtask

    // Waits for the backlog to retire, bounded by its size
    task automatic wait_drain();
        int limit;
        int waited;
        repeat (2) @(posedge clk);
        limit  = 20 * exp_q.size() + 20;
        waited = 0;
        while (exp_q.size() != 0 && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        assert (exp_q.size() == 0)
            else begin
                err_other++;
                $display("%0d accepted commands never retired", exp_q.size());
            end
    endtask

    initial begin
        seed        = 34;
        next_pc     = 32'h0000_1000;
        rst_n       = 1'b0;
        insts_valid = '0;
        insts       = '0;
        in_burst    = 1'b0;
        for (int r = 0; r < rvv_pkg::NUM_VREG; r++) begin
            vrf_m[r] = {(VLEN/8){r[7:0]}};
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        // Dependent chain across widths, then illegal writes to v6
        add_cmd(K_ADD, 1, 3, 2, 0);
        add_cmd(K_SUB, 4, 2, 1, 1);
        add_cmd(K_ADD, 5, 4, 4, 2);
        add_cmd(K_SUB, 1, 5, 1, 0);
        add_cmd(K_BAD_OPC, 6, 1, 2, 0);
        add_cmd(K_BAD_F3, 6, 1, 2, 1);
        add_cmd(K_BAD_F6, 6, 1, 2, 2);
        add_cmd(K_BAD_SEW, 6, 1, 2, 0);
        add_cmd(K_ADD, 7, 0, 6, 2);
        add_cmd(K_SUB, 8, 6, 7, 1);
        run_stream(1'b0);
        wait_drain();

        repeat (N_RANDOM) add_random_cmd();
        run_stream(1'b0);
        wait_drain();

        // Both lanes every cycle until the queues push back
        repeat (N_BURST) add_random_cmd();
        in_burst <= 1'b1;
        run_stream(1'b1);
        in_burst <= 1'b0;
        wait_drain();
        repeat (10) @(posedge clk);

        assert (saw_ready_low)
            else begin
                err_other++;
                $display("insts_ready never fell during the two-lane burst");
            end

        $display("checks done: %0d value mismatches, %0d other errors", err_value, err_other);
        if (err_value == 0 && err_other == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- hw/rvv_backend.sv
`timescale 1ns/1ps

module rvv_backend #(
    parameter int CQ_DEPTH = 8,
    parameter int UQ_DEPTH = 4
) (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic [rvv_pkg::ISSUE_LANE-1:0]               insts_valid,
    input  rvv_pkg::rvv_cmd_t [rvv_pkg::ISSUE_LANE-1:0]  insts,
    output logic [rvv_pkg::ISSUE_LANE-1:0]               insts_ready,
    output logic                                         rt_valid,
    output logic [31:0]                                  rt_pc,
    output logic [rvv_pkg::VREG_IDX_W-1:0]               rt_vd,
    output logic [rvv_pkg::VLEN-1:0]                     rt_data,
    output logic                                         rt_illegal
);

    // Command queue
    logic                                cq_full;
    logic [rvv_pkg::ISSUE_LANE-1:1]      cq_almost_full;
    logic                                cq_empty;
    logic                                cq_pop;
    rvv_pkg::rvv_cmd_t                   cq_data;
    // Micro-op queue
    logic                                uq_push;
    rvv_pkg::uop_t                       uq_wdata;
    logic                                uq_full;
    logic                                uq_empty;
    logic                                uq_pop;
    rvv_pkg::uop_t                       uq_rdata;
    // Register reads
    logic [rvv_pkg::VREG_IDX_W-1:0]      rd_idx_a;
    logic [rvv_pkg::VREG_IDX_W-1:0]      rd_idx_b;
    logic [rvv_pkg::VLEN-1:0]            rd_data_a;
    logic [rvv_pkg::VLEN-1:0]            rd_data_b;
    // Issue and write-back
    logic                                iss_valid;
    rvv_pkg::uop_t                       iss_uop;
    logic [rvv_pkg::VLEN-1:0]            iss_src_a;
    logic [rvv_pkg::VLEN-1:0]            iss_src_b;
    logic                                wb_valid;
    logic [31:0]                         wb_pc;
    logic [rvv_pkg::VREG_IDX_W-1:0]      wb_vd;
    logic [rvv_pkg::VLEN-1:0]            wb_data;
    logic                                wb_illegal;

    multi_fifo #(
        .T     (rvv_pkg::rvv_cmd_t),
        .M     (rvv_pkg::ISSUE_LANE),
        .N     (1),
        .DEPTH (CQ_DEPTH)
    ) u_command_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .push         (insts_valid & insts_ready),
        .datain       (insts),
        .pop          (cq_pop),
        .dataout      (cq_data),
        .full         (cq_full),
        .almost_full  (cq_almost_full),
        .empty        (cq_empty),
        .almost_empty ()
    );

    // Lane k needs k+1 free slots and every lower lane ready
    always_comb begin
        insts_ready[0] = ~cq_full;
        for (int k = 1; k < rvv_pkg::ISSUE_LANE; k++) begin
            insts_ready[k] = insts_ready[k-1] & ~cq_almost_full[k];
        end
    end

    rvv_decode u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .cq_empty (cq_empty),
        .cq_data  (cq_data),
        .cq_pop   (cq_pop),
        .uq_full  (uq_full),
        .uq_push  (uq_push),
        .uq_wdata (uq_wdata)
    );

    multi_fifo #(
        .T     (rvv_pkg::uop_t),
        .M     (1),
        .N     (1),
        .DEPTH (UQ_DEPTH)
    ) u_uop_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .push         (uq_push),
        .datain       (uq_wdata),
        .pop          (uq_pop),
        .dataout      (uq_rdata),
        .full         (uq_full),
        .almost_full  (),
        .empty        (uq_empty),
        .almost_empty ()
    );

    rvv_dispatch u_dispatch (
        .clk        (clk),
        .rst_n      (rst_n),
        .uq_empty   (uq_empty),
        .uq_rdata   (uq_rdata),
        .uq_pop     (uq_pop),
        .rd_idx_a   (rd_idx_a),
        .rd_idx_b   (rd_idx_b),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b),
        .wb_valid   (wb_valid),
        .wb_vd      (wb_vd),
        .wb_illegal (wb_illegal),
        .iss_valid  (iss_valid),
        .iss_uop    (iss_uop),
        .iss_src_a  (iss_src_a),
        .iss_src_b  (iss_src_b)
    );

    rvv_alu u_alu (
        .clk        (clk),
        .rst_n      (rst_n),
        .iss_valid  (iss_valid),
        .iss_uop    (iss_uop),
        .iss_src_a  (iss_src_a),
        .iss_src_b  (iss_src_b),
        .wb_valid   (wb_valid),
        .wb_pc      (wb_pc),
        .wb_vd      (wb_vd),
        .wb_data    (wb_data),
        .wb_illegal (wb_illegal)
    );

    rvv_vrf u_vrf (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_idx_a   (rd_idx_a),
        .rd_idx_b   (rd_idx_b),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b),
        .wb_valid   (wb_valid),
        .wb_illegal (wb_illegal),
        .wb_vd      (wb_vd),
        .wb_data    (wb_data)
    );

    // In-order issue with fixed latency, so write-back is the retire port
    assign rt_valid   = wb_valid;
    assign rt_pc      = wb_pc;
    assign rt_vd      = wb_vd;
    assign rt_data    = wb_data;
    assign rt_illegal = wb_illegal;

endmodule

//--- hw/rvv_vrf.sv
`timescale 1ns/1ps

module rvv_vrf (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [rvv_pkg::VREG_IDX_W-1:0]   rd_idx_a,
    input  logic [rvv_pkg::VREG_IDX_W-1:0]   rd_idx_b,
    output logic [rvv_pkg::VLEN-1:0]         rd_data_a,
    output logic [rvv_pkg::VLEN-1:0]         rd_data_b,
    input  logic                             wb_valid,
    input  logic                             wb_illegal,
    input  logic [rvv_pkg::VREG_IDX_W-1:0]   wb_vd,
    input  logic [rvv_pkg::VLEN-1:0]         wb_data
);

    logic [rvv_pkg::VLEN-1:0] vreg [rvv_pkg::NUM_VREG];

    // Reset loads the known pattern used by the reference model
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < rvv_pkg::NUM_VREG; r++) begin
                vreg[r] <= rvv_pkg::vrf_reset_value(r);
            end
        end else if (wb_valid && !wb_illegal) begin
            vreg[wb_vd] <= wb_data;
        end
    end

    // No bypass, a write is seen on the cycle after
    assign rd_data_a = vreg[rd_idx_a];
    assign rd_data_b = vreg[rd_idx_b];

endmodule

//--- hw/rvv_alu.sv
`timescale 1ns/1ps

module rvv_alu (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             iss_valid,
    input  rvv_pkg::uop_t                    iss_uop,
    input  logic [rvv_pkg::VLEN-1:0]         iss_src_a,
    input  logic [rvv_pkg::VLEN-1:0]         iss_src_b,
    output logic                             wb_valid,
    output logic [31:0]                      wb_pc,
    output logic [rvv_pkg::VREG_IDX_W-1:0]   wb_vd,
    output logic [rvv_pkg::VLEN-1:0]         wb_data,
    output logic                             wb_illegal
);

    localparam int NB = rvv_pkg::VLEN / 8;

    logic          s1_valid;
    rvv_pkg::uop_t s1_uop;
    // Byte-lane sums for carry-in 0 and 1, carry out in bit 8
    logic [8:0]    s1_sum0 [NB];
    logic [8:0]    s1_sum1 [NB];
    logic [rvv_pkg::VLEN-1:0] joined;

    // Stage 1: per-byte carry-select add, subtract via inverted b
    always_ff @(posedge clk) begin
        logic [7:0] b_eff;
        for (int i = 0; i < NB; i++) begin
            b_eff = (iss_uop.alu_op == rvv_pkg::ALU_SUB) ? ~iss_src_b[8*i +: 8]
                                                          : iss_src_b[8*i +: 8];
            s1_sum0[i] <= {1'b0, iss_src_a[8*i +: 8]} + {1'b0, b_eff};
            s1_sum1[i] <= {1'b0, iss_src_a[8*i +: 8]} + {1'b0, b_eff} + 9'd1;
        end
        s1_uop <= iss_uop;
    end

    // Stage 2: carries ripple across bytes, restart at element boundaries
    always_comb begin
        logic       carry;
        logic       cin;
        logic       elem_start;
        logic [8:0] sel;
        carry = 1'b0;
        for (int i = 0; i < NB; i++) begin
            case (s1_uop.sew)
                rvv_pkg::SEW_16: elem_start = (i % 2) == 0;
                rvv_pkg::SEW_32: elem_start = (i % 4) == 0;
                default:         elem_start = 1'b1;
            endcase
            cin = elem_start ? (s1_uop.alu_op == rvv_pkg::ALU_SUB) : carry;
            sel = cin ? s1_sum1[i] : s1_sum0[i];
            joined[8*i +: 8] = sel[7:0];
            carry = sel[8];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            s1_valid <= iss_valid;
            wb_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_pc      <= s1_uop.pc;
        wb_vd      <= s1_uop.vd;
        wb_illegal <= s1_uop.illegal;
        wb_data    <= s1_uop.illegal ? '0 : joined;
    end

endmodule

//--- hw/rvv_dispatch.sv
`timescale 1ns/1ps

module rvv_dispatch (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             uq_empty,
    input  rvv_pkg::uop_t                    uq_rdata,
    output logic                             uq_pop,
    output logic [rvv_pkg::VREG_IDX_W-1:0]   rd_idx_a,
    output logic [rvv_pkg::VREG_IDX_W-1:0]   rd_idx_b,
    input  logic [rvv_pkg::VLEN-1:0]         rd_data_a,
    input  logic [rvv_pkg::VLEN-1:0]         rd_data_b,
    input  logic                             wb_valid,
    input  logic [rvv_pkg::VREG_IDX_W-1:0]   wb_vd,
    input  logic                             wb_illegal,
    output logic                             iss_valid,
    output rvv_pkg::uop_t                    iss_uop,
    output logic [rvv_pkg::VLEN-1:0]         iss_src_a,
    output logic [rvv_pkg::VLEN-1:0]         iss_src_b
);

    // One bit per vector register with a write in flight
    logic [rvv_pkg::NUM_VREG-1:0] busy;
    logic [rvv_pkg::NUM_VREG-1:0] busy_nxt;
    logic                         hazard;

    // Operand a is vs2, operand b is vs1
    assign rd_idx_a = uq_rdata.vs2;
    assign rd_idx_b = uq_rdata.vs1;

    assign hazard = busy[uq_rdata.vs1] | busy[uq_rdata.vs2] | busy[uq_rdata.vd];

    // Illegal ops touch no register, so they never wait
    assign uq_pop = ~uq_empty & (uq_rdata.illegal | ~hazard);

    always_comb begin
        busy_nxt = busy;
        // Cleared on the same edge the VRF takes the write
        if (wb_valid && !wb_illegal) begin
            busy_nxt[wb_vd] = 1'b0;
        end
        if (uq_pop && !uq_rdata.illegal) begin
            busy_nxt[uq_rdata.vd] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= '0;
            iss_valid <= 1'b0;
        end else begin
            busy      <= busy_nxt;
            iss_valid <= uq_pop;
        end
    end

    // Operands captured together with the micro-op
    always_ff @(posedge clk) begin
        if (uq_pop) begin
            iss_uop   <= uq_rdata;
            iss_src_a <= rd_data_a;
            iss_src_b <= rd_data_b;
        end
    end

endmodule

//--- hw/rvv_decode.sv
`timescale 1ns/1ps

module rvv_decode (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cq_empty,
    input  rvv_pkg::rvv_cmd_t cq_data,
    output logic              cq_pop,
    input  logic              uq_full,
    output logic              uq_push,
    output rvv_pkg::uop_t     uq_wdata
);

    logic [6:0]    opcode;
    logic [2:0]    funct3;
    logic [5:0]    funct6;
    logic          out_valid;
    rvv_pkg::uop_t dec_uop;

    assign opcode = cq_data.inst[6:0];
    assign funct3 = cq_data.inst[14:12];
    assign funct6 = cq_data.inst[31:26];

    always_comb begin
        dec_uop.pc     = cq_data.pc;
        dec_uop.vd     = cq_data.inst[11:7];
        dec_uop.vs1    = cq_data.inst[19:15];
        dec_uop.vs2    = cq_data.inst[24:20];
        dec_uop.sew    = cq_data.sew;
        dec_uop.alu_op = (funct6 == rvv_pkg::F6_VSUB) ? rvv_pkg::ALU_SUB : rvv_pkg::ALU_ADD;
        dec_uop.illegal = (opcode != rvv_pkg::OPC_OP_V) ||
                          (funct3 != rvv_pkg::F3_OPIVV) ||
                          !(funct6 inside {rvv_pkg::F6_VADD, rvv_pkg::F6_VSUB}) ||
                          !(cq_data.sew inside {rvv_pkg::SEW_8, rvv_pkg::SEW_16,
                                                rvv_pkg::SEW_32});
    end

    // Output register holds its micro-op while the queue is full
    assign uq_push = out_valid & ~uq_full;
    assign cq_pop  = ~cq_empty & (~out_valid | uq_push);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= cq_pop | (out_valid & ~uq_push);
        end
    end

    always_ff @(posedge clk) begin
        if (cq_pop) begin
            uq_wdata <= dec_uop;
        end
    end

endmodule

//--- hw/multi_fifo.sv
`timescale 1ns/1ps

module multi_fifo #(
    parameter type T     = logic [7:0],
    parameter int  M     = 2,
    parameter int  N     = 1,
    parameter int  DEPTH = 8,
    // Level flag index ranges, kept one bit wide for single-lane sides
    parameter int  AF_HI = (M > 1) ? M - 1 : 1,
    parameter int  AE_HI = (N > 1) ? N - 1 : 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [M-1:0]     push,
    input  T     [M-1:0]     datain,
    input  logic [N-1:0]     pop,
    output T     [N-1:0]     dataout,
    output logic             full,
    output logic [AF_HI:1]   almost_full,
    output logic             empty,
    output logic [AE_HI:1]   almost_empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wptr;
    logic [PTR_W-1:0] rptr;
    logic [CNT_W-1:0] count;
    logic [PTR_W-1:0] wr_addr [M];
    logic [CNT_W-1:0] push_cnt;
    logic [CNT_W-1:0] pop_cnt;

    // Pointer step with wrap at DEPTH, offset never exceeds DEPTH
    function automatic logic [PTR_W-1:0] ptr_add(input logic [PTR_W-1:0] ptr,
                                                 input int unsigned off);
        int unsigned sum;
        sum = ptr + off;
        if (sum >= DEPTH) begin
            sum = sum - DEPTH;
        end
        return PTR_W'(sum);
    endfunction

    // Pushed lanes land in consecutive slots in lane order
    always_comb begin
        push_cnt = '0;
        for (int i = 0; i < M; i++) begin
            wr_addr[i] = ptr_add(wptr, push_cnt);
            if (push[i]) begin
                push_cnt = push_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        pop_cnt = '0;
        for (int j = 0; j < N; j++) begin
            if (pop[j]) begin
                pop_cnt = pop_cnt + 1'b1;
            end
        end
    end

    // Oldest N entries at the read side
    always_comb begin
        for (int j = 0; j < N; j++) begin
            dataout[j] = mem[ptr_add(rptr, j)];
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < M; i++) begin
            if (push[i]) begin
                mem[wr_addr[i]] <= datain[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            wptr  <= ptr_add(wptr, push_cnt);
            rptr  <= ptr_add(rptr, pop_cnt);
            count <= count + push_cnt - pop_cnt;
        end
    end

    // Levels from the registered count only
    assign full  = (int'(count) == DEPTH);
    assign empty = (count == '0);

    always_comb begin
        for (int k = 1; k <= AF_HI; k++) begin
            // Fewer than k+1 free slots
            almost_full[k] = (int'(count) + k + 1) > DEPTH;
        end
        for (int k = 1; k <= AE_HI; k++) begin
            // Fewer than k+1 entries held
            almost_empty[k] = int'(count) < (k + 1);
        end
    end

endmodule

//--- hw/rvv_pkg.sv
package rvv_pkg;

    localparam int VLEN       = 128;
    localparam int NUM_VREG   = 32;
    localparam int VREG_IDX_W = 5;
    localparam int ISSUE_LANE = 2;

    // Instruction field encodings for OPIVV add/sub
    localparam logic [6:0] OPC_OP_V = 7'b1010111;
    localparam logic [2:0] F3_OPIVV = 3'b000;
    localparam logic [5:0] F6_VADD  = 6'b000000;
    localparam logic [5:0] F6_VSUB  = 6'b000010;

    // Encoding 3 is reserved and decodes as illegal
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2
    } sew_e;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        sew_e        sew;
    } rvv_cmd_t;

    typedef enum logic {
        ALU_ADD = 1'b0,
        ALU_SUB = 1'b1
    } alu_op_e;

    typedef struct packed {
        logic [31:0]           pc;
        logic [VREG_IDX_W-1:0] vd;
        logic [VREG_IDX_W-1:0] vs1;
        logic [VREG_IDX_W-1:0] vs2;
        sew_e                  sew;
        alu_op_e               alu_op;
        logic                  illegal;
    } uop_t;

    // VRF reset rule: every byte of register r holds the value r
    function automatic logic [VLEN-1:0] vrf_reset_value(input int unsigned idx);
        logic [7:0] byte_val;
        byte_val = 8'(idx);
        return {(VLEN/8){byte_val}};
    endfunction

endpackage
